//--- source/ising_settings.svh
/* Ising annealer sizes, register map and reset values */

`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// Array sizes
`define ISING_NUM_SPIN      8
`define ISING_J_BITS        4
`define ISING_H_BITS        4
`define ISING_FIELD_BITS    8
`define ISING_SWEEP_BITS    8

// APB bus
`define ISING_APB_ADDR_BITS 12
`define ISING_APB_DATA_BITS 32

// Register offsets
`define ISING_REG_CTRL      12'h000
`define ISING_REG_SWEEPS    12'h004
`define ISING_REG_SPIN      12'h008
`define ISING_REG_STATUS    12'h00C
`define ISING_REG_HBIAS     12'h010
`define ISING_REG_JROW_BASE 12'h040

// Register reset values
`define ISING_SWEEPS_RESET  8'h00
`define ISING_SPIN_RESET    8'h00
`define ISING_HBIAS_RESET   32'h0000_0000

`endif

//--- source/ising_pkg.sv
/*
 * Ising annealer types: vector widths, APB structs,
 * pipeline payloads and the sequencer state
 */

`default_nettype none

`include "ising_settings.svh"

package ising_pkg;

    // Spin bit 1 is +1, bit 0 is -1
    typedef logic [`ISING_NUM_SPIN-1:0]                 spin_vec_t;
    typedef logic [$clog2(`ISING_NUM_SPIN)-1:0]         spin_idx_t;
    typedef logic [`ISING_NUM_SPIN*`ISING_J_BITS-1:0]   j_row_t;
    typedef logic [`ISING_NUM_SPIN*`ISING_H_BITS-1:0]   h_vec_t;
    typedef logic signed [`ISING_FIELD_BITS-1:0]        field_t;
    typedef logic [`ISING_SWEEP_BITS-1:0]               sweep_cnt_t;
    typedef logic [$clog2(`ISING_NUM_SPIN):0]           flip_cnt_t;

    ////////////////////////////////////////
    // APB
    ////////////////////////////////////////
    typedef struct packed {
        logic                            psel;
        logic                            penable;
        logic                            pwrite;
        logic [`ISING_APB_ADDR_BITS-1:0] paddr;
        logic [`ISING_APB_DATA_BITS-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`ISING_APB_DATA_BITS-1:0] prdata;
        logic                            pready;
        logic                            pslverr;
    } apb_rsp_t;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////
    typedef struct packed {
        logic                            valid;
        spin_idx_t                       row;
        j_row_t                          j_row;
        logic signed [`ISING_H_BITS-1:0] h;
        logic                            last;
    } fetch_item_t;

    typedef struct packed {
        logic      valid;
        spin_idx_t row;
        field_t    field;
        logic      last;
    } field_item_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_t;

endpackage

`default_nettype wire

//--- source/ising_apb_regs.sv
/*
 * APB register slave of the Ising core: control, sweep count,
 * bias and spin registers, status and J row write forwarding
 */

`timescale 1ns/10ps
`default_nettype none

`include "ising_settings.svh"

module ising_apb_regs import ising_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  apb_req_t   apb_req_i,
    input  logic       busy_i,
    input  logic       done_set_i,
    input  logic       spin_commit_valid_i,
    input  spin_vec_t  spin_commit_i,
    input  flip_cnt_t  flip_count_i,
    output apb_rsp_t   apb_rsp_o,
    output logic       start_o,
    output sweep_cnt_t sweeps_o,
    output spin_vec_t  spins_o,
    output h_vec_t     h_bias_o,
    output logic       j_wr_en_o,
    output spin_idx_t  j_wr_row_o,
    output j_row_t     j_wr_data_o,
    output logic       done_o
);

    logic access;
    logic wr_access;
    logic wr_allowed;
    logic hit_ctrl;
    logic hit_sweeps;
    logic hit_spin;
    logic hit_status;
    logic hit_hbias;
    logic hit_jrow;
    logic mapped;
    logic busy_err;
    logic [`ISING_APB_ADDR_BITS-1:0] jrow_off;

    sweep_cnt_t sweeps_q;
    spin_vec_t  spins_q;
    h_vec_t     h_bias_q;
    logic       done_q;
    flip_cnt_t  flips_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign access    = apb_req_i.psel & apb_req_i.penable;
    assign wr_access = access & apb_req_i.pwrite;

    assign hit_ctrl   = (apb_req_i.paddr == `ISING_REG_CTRL);
    assign hit_sweeps = (apb_req_i.paddr == `ISING_REG_SWEEPS);
    assign hit_spin   = (apb_req_i.paddr == `ISING_REG_SPIN);
    assign hit_status = (apb_req_i.paddr == `ISING_REG_STATUS);
    assign hit_hbias  = (apb_req_i.paddr == `ISING_REG_HBIAS);

    // Addresses below the base wrap to a large offset and miss
    assign jrow_off = apb_req_i.paddr - `ISING_REG_JROW_BASE;
    assign hit_jrow = (jrow_off < 4 * `ISING_NUM_SPIN) && (jrow_off[1:0] == 2'b00);

    assign mapped   = hit_ctrl | hit_sweeps | hit_spin | hit_status | hit_hbias | hit_jrow;
    assign busy_err = busy_i & (hit_sweeps | hit_spin | hit_hbias | hit_jrow);

    // Config writes only land while the core is idle
    assign wr_allowed = wr_access & ~busy_i;

    assign start_o = wr_allowed & hit_ctrl & apb_req_i.pwdata[0];

    ////////////////////////////////////////
    // Read data and response
    ////////////////////////////////////////
    always_comb begin
        apb_rsp_o         = '0;
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = access & (~mapped | (apb_req_i.pwrite & busy_err));
        if (hit_sweeps) begin
            apb_rsp_o.prdata[`ISING_SWEEP_BITS-1:0] = sweeps_q;
        end
        if (hit_spin) begin
            apb_rsp_o.prdata[`ISING_NUM_SPIN-1:0] = spins_q;
        end
        if (hit_status) begin
            apb_rsp_o.prdata[0]    = busy_i;
            apb_rsp_o.prdata[1]    = done_q;
            apb_rsp_o.prdata[11:8] = flips_q;
        end
        if (hit_hbias) begin
            apb_rsp_o.prdata = h_bias_q;
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sweeps_q <= `ISING_SWEEPS_RESET;
            spins_q  <= `ISING_SPIN_RESET;
            h_bias_q <= `ISING_HBIAS_RESET;
            done_q   <= 1'b0;
            flips_q  <= '0;
        end else begin
            if (wr_allowed && hit_sweeps) begin
                sweeps_q <= apb_req_i.pwdata[`ISING_SWEEP_BITS-1:0];
            end
            if (wr_allowed && hit_hbias) begin
                h_bias_q <= apb_req_i.pwdata;
            end
            // Sweep results, loaded once per sweep
            if (spin_commit_valid_i) begin
                spins_q <= spin_commit_i;
                flips_q <= flip_count_i;
            end else if (wr_allowed && hit_spin) begin
                spins_q <= apb_req_i.pwdata[`ISING_NUM_SPIN-1:0];
            end
            // Zero-sweep start sets done in the same edge
            if (done_set_i) begin
                done_q <= 1'b1;
            end else if (start_o) begin
                done_q <= 1'b0;
            end
        end
    end

    assign sweeps_o = sweeps_q;
    assign spins_o  = spins_q;
    assign h_bias_o = h_bias_q;
    assign done_o   = done_q;

    assign j_wr_en_o   = wr_allowed & hit_jrow;
    assign j_wr_row_o  = spin_idx_t'(jrow_off >> 2);
    assign j_wr_data_o = apb_req_i.pwdata;

endmodule

`default_nettype wire

//--- source/coupling_mem.sv
/* Coupling row memory, one J row per entry, with a registered read port */

`timescale 1ns/10ps
`default_nettype none

module coupling_mem import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      wr_en_i,
    input  spin_idx_t wr_row_i,
    input  j_row_t    wr_data_i,
    input  logic      rd_en_i,
    input  spin_idx_t rd_row_i,
    output j_row_t    rd_data_o
);

    j_row_t mem_q [2**$bits(spin_idx_t)];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_row_i] <= wr_data_i;
        end
    end

    // Read data follows the enable by one cycle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_row_i];
        end
    end

endmodule

`default_nettype wire

//--- source/sweep_sequencer.sv
/*
 * Sweep sequencer: issues one J row per cycle, snapshots the spins
 * per sweep, counts sweeps and commits each sweep result
 */

`timescale 1ns/10ps
`default_nettype none

`include "ising_settings.svh"

module sweep_sequencer import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        start_i,
    input  sweep_cnt_t  sweeps_i,
    input  spin_vec_t   spins_i,
    input  h_vec_t      h_bias_i,
    input  j_row_t      j_rd_data_i,
    input  logic        decide_done_i,
    input  spin_vec_t   next_spins_i,
    input  flip_cnt_t   flip_count_i,
    output logic        j_rd_en_o,
    output spin_idx_t   j_rd_row_o,
    output fetch_item_t fetch_o,
    output spin_vec_t   sweep_spins_o,
    output logic        busy_o,
    output logic        done_set_o,
    output logic        spin_commit_valid_o,
    output spin_vec_t   spin_commit_o,
    output flip_cnt_t   flip_count_o
);

    seq_state_t state_q;
    spin_idx_t  row_q;
    sweep_cnt_t sweeps_left_q;
    spin_vec_t  snapshot_q;
    logic       last_row;
    logic       last_sweep;
    logic       sweep_end;

    // Row tag, aligned with the memory read latency
    logic                            tag_valid_q;
    spin_idx_t                       tag_row_q;
    logic                            tag_last_q;
    logic signed [`ISING_H_BITS-1:0] tag_h_q;

    assign last_row   = (row_q == spin_idx_t'(`ISING_NUM_SPIN - 1));
    assign last_sweep = (sweeps_left_q == sweep_cnt_t'(1));
    assign sweep_end  = (state_q == SEQ_DRAIN) && decide_done_i;

    ////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= SEQ_IDLE;
            row_q         <= '0;
            sweeps_left_q <= '0;
            snapshot_q    <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i && (sweeps_i != '0)) begin
                        state_q       <= SEQ_ISSUE;
                        row_q         <= '0;
                        sweeps_left_q <= sweeps_i;
                        snapshot_q    <= spins_i;
                    end
                end
                SEQ_ISSUE: begin
                    row_q <= row_q + 1'b1;
                    if (last_row) begin
                        state_q <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    if (decide_done_i) begin
                        if (last_sweep) begin
                            state_q <= SEQ_IDLE;
                        end else begin
                            // Next sweep starts from this result
                            state_q       <= SEQ_ISSUE;
                            row_q         <= '0;
                            sweeps_left_q <= sweeps_left_q - 1'b1;
                            snapshot_q    <= next_spins_i;
                        end
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Row fetch
    ////////////////////////////////////////
    assign j_rd_en_o  = (state_q == SEQ_ISSUE);
    assign j_rd_row_o = row_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tag_valid_q <= 1'b0;
        end else begin
            tag_valid_q <= j_rd_en_o;
        end
    end

    always_ff @(posedge clk_i) begin
        tag_row_q  <= row_q;
        tag_last_q <= last_row;
        tag_h_q    <= h_bias_i[row_q*`ISING_H_BITS +: `ISING_H_BITS];
    end

    always_comb begin
        fetch_o.valid = tag_valid_q;
        fetch_o.row   = tag_row_q;
        fetch_o.j_row = j_rd_data_i;
        fetch_o.h     = tag_h_q;
        fetch_o.last  = tag_last_q;
    end

    ////////////////////////////////////////
    // Status and commit
    ////////////////////////////////////////
    assign busy_o        = (state_q != SEQ_IDLE);
    assign sweep_spins_o = snapshot_q;

    // A start with zero sweeps finishes at once
    assign done_set_o = ((state_q == SEQ_IDLE) && start_i && (sweeps_i == '0)) ||
                        (sweep_end && last_sweep);

    assign spin_commit_valid_o = sweep_end;
    assign spin_commit_o       = next_spins_i;
    assign flip_count_o        = flip_count_i;

endmodule

`default_nettype wire

//--- source/field_accumulate.sv
/* Local-field stage: h plus the signed J products of one row against the snapshot */

`timescale 1ns/10ps
`default_nettype none

`include "ising_settings.svh"

module field_accumulate import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  fetch_item_t fetch_i,
    input  spin_vec_t   sweep_spins_i,
    output field_item_t field_o
);

    field_t                          sum;
    field_t                          term;
    logic signed [`ISING_J_BITS-1:0] j_val;

    always_comb begin
        sum   = fetch_i.h;
        term  = '0;
        j_val = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            j_val = fetch_i.j_row[j*`ISING_J_BITS +: `ISING_J_BITS];
            term  = j_val;
            // Diagonal term does not couple a spin to itself
            if (j != int'(fetch_i.row)) begin
                if (sweep_spins_i[j]) begin
                    sum = sum + term;
                end else begin
                    sum = sum - term;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            field_o <= '0;
        end else begin
            field_o.valid <= fetch_i.valid;
            field_o.row   <= fetch_i.row;
            field_o.field <= sum;
            field_o.last  <= fetch_i.last;
        end
    end

endmodule

`default_nettype wire

//--- source/spin_decide.sv
/* Spin decision stage: sign rule per row, next vector build-up and flip count */

`timescale 1ns/10ps
`default_nettype none

module spin_decide import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  field_item_t field_i,
    input  spin_vec_t   sweep_spins_i,
    output logic        decide_done_o,
    output spin_vec_t   next_spins_o,
    output flip_cnt_t   flip_count_o
);

    spin_vec_t work_vec_q;
    flip_cnt_t work_cnt_q;
    spin_vec_t vec_next;
    flip_cnt_t cnt_next;
    logic      old_spin;
    logic      new_spin;

    always_comb begin
        old_spin = sweep_spins_i[field_i.row];
        // Zero field keeps the old spin
        if (field_i.field > 0) begin
            new_spin = 1'b1;
        end else if (field_i.field < 0) begin
            new_spin = 1'b0;
        end else begin
            new_spin = old_spin;
        end
        vec_next               = work_vec_q;
        vec_next[field_i.row]  = new_spin;
        cnt_next               = work_cnt_q + flip_cnt_t'(new_spin ^ old_spin);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decide_done_o <= 1'b0;
            work_cnt_q    <= '0;
        end else begin
            decide_done_o <= field_i.valid & field_i.last;
            if (field_i.valid) begin
                work_cnt_q <= field_i.last ? '0 : cnt_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (field_i.valid) begin
            work_vec_q <= vec_next;
            if (field_i.last) begin
                next_spins_o <= vec_next;
                flip_count_o <= cnt_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ising_core_top.sv
/* Digital Ising annealer top: APB registers, J memory and the sweep pipeline */

`timescale 1ns/10ps
`default_nettype none

module ising_core_top import ising_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    output logic     done_o
);

    logic        start;
    sweep_cnt_t  sweeps;
    spin_vec_t   spins;
    h_vec_t      h_bias;
    logic        busy;
    logic        done_set;
    logic        spin_commit_valid;
    spin_vec_t   spin_commit;
    flip_cnt_t   commit_flips;

    logic        j_wr_en;
    spin_idx_t   j_wr_row;
    j_row_t      j_wr_data;
    logic        j_rd_en;
    spin_idx_t   j_rd_row;
    j_row_t      j_rd_data;

    fetch_item_t fetch;
    field_item_t field;
    spin_vec_t   sweep_spins;
    logic        decide_done;
    spin_vec_t   next_spins;
    flip_cnt_t   decide_flips;

    ////////////////////////////////////////
    // Registers and J memory
    ////////////////////////////////////////
    ising_apb_regs u_regs (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .apb_req_i           (apb_req_i),
        .busy_i              (busy),
        .done_set_i          (done_set),
        .spin_commit_valid_i (spin_commit_valid),
        .spin_commit_i       (spin_commit),
        .flip_count_i        (commit_flips),
        .apb_rsp_o           (apb_rsp_o),
        .start_o             (start),
        .sweeps_o            (sweeps),
        .spins_o             (spins),
        .h_bias_o            (h_bias),
        .j_wr_en_o           (j_wr_en),
        .j_wr_row_o          (j_wr_row),
        .j_wr_data_o         (j_wr_data),
        .done_o              (done_o)
    );

    coupling_mem u_jmem (
        .clk_i     (clk_i),
        .wr_en_i   (j_wr_en),
        .wr_row_i  (j_wr_row),
        .wr_data_i (j_wr_data),
        .rd_en_i   (j_rd_en),
        .rd_row_i  (j_rd_row),
        .rd_data_o (j_rd_data)
    );

    ////////////////////////////////////////
    // Sweep pipeline
    ////////////////////////////////////////
    sweep_sequencer u_seq (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .start_i             (start),
        .sweeps_i            (sweeps),
        .spins_i             (spins),
        .h_bias_i            (h_bias),
        .j_rd_data_i         (j_rd_data),
        .decide_done_i       (decide_done),
        .next_spins_i        (next_spins),
        .flip_count_i        (decide_flips),
        .j_rd_en_o           (j_rd_en),
        .j_rd_row_o          (j_rd_row),
        .fetch_o             (fetch),
        .sweep_spins_o       (sweep_spins),
        .busy_o              (busy),
        .done_set_o          (done_set),
        .spin_commit_valid_o (spin_commit_valid),
        .spin_commit_o       (spin_commit),
        .flip_count_o        (commit_flips)
    );

    field_accumulate u_accum (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_i       (fetch),
        .sweep_spins_i (sweep_spins),
        .field_o       (field)
    );

    spin_decide u_decide (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .field_i       (field),
        .sweep_spins_i (sweep_spins),
        .decide_done_o (decide_done),
        .next_spins_o  (next_spins),
        .flip_count_o  (decide_flips)
    );

endmodule

`default_nettype wire

//--- verification/ising_props.sv
/* Bound APB and status properties for the Ising core */

`timescale 1ns/10ps
`default_nettype none

module ising_props import ising_pkg::*; (
    input logic     clk_i,
    input logic     reset_i,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input logic     busy_i,
    input logic     done_i
);

    // Count of failed assertions
    int assert_failures = 0;

    // Zero wait-state slave
    pready_in_access: assert property (
        @(posedge clk_i) disable iff (reset_i)
        apb_req_i.penable |-> apb_rsp_i.pready
    ) else begin
        $error("pready low while penable is high");
        assert_failures++;
    end

    busy_done_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(busy_i && done_i)
    ) else begin
        $error("busy and done high in the same cycle");
        assert_failures++;
    end

    slverr_in_access: assert property (
        @(posedge clk_i) disable iff (reset_i)
        apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable)
    ) else begin
        $error("pslverr outside an APB access cycle");
        assert_failures++;
    end

endmodule

bind ising_core_top ising_props u_props (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_i (apb_rsp_o),
    .busy_i    (busy),
    .done_i    (done_o)
);

`default_nettype wire

//--- verification/ising_checker.sv
/*
 * APB response checker: compares read data, pslverr and the
 * done pin against the values the testbench expects
 */

`timescale 1ns/10ps
`default_nettype none

`include "ising_settings.svh"

module ising_checker import ising_pkg::*; (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  apb_req_t                        apb_req_i,
    input  apb_rsp_t                        apb_rsp_i,
    input  logic                            done_i,
    input  logic [`ISING_APB_DATA_BITS-1:0] exp_data_i,
    input  logic                            exp_err_i,
    input  logic                            check_data_i,
    input  logic                            sweep_stuck_i,
    output int                              mismatch_count_o,
    output int                              failure_count_o
);

    int   mismatches;
    int   failures;
    logic access_done;
    logic data_check;

    // Zero wait states, so every access cycle completes
    assign access_done = apb_req_i.psel & apb_req_i.penable & apb_rsp_i.pready;
    assign data_check  = access_done & check_data_i & ~apb_req_i.pwrite;

    always @(posedge clk_i) begin
        if (reset_i) begin
            mismatches = 0;
            failures   = 0;
        end else begin
            if (access_done && apb_rsp_i.pslverr !== exp_err_i) begin
                $display("Mismatch at %0t ns: pslverr expected %b, got %b (paddr 0x%03h)",
                         $time, exp_err_i, apb_rsp_i.pslverr, apb_req_i.paddr);
                mismatches++;
            end
            if (data_check && apb_rsp_i.prdata !== exp_data_i) begin
                $display("Mismatch at %0t ns: prdata expected 0x%08h, got 0x%08h (paddr 0x%03h)",
                         $time, exp_data_i, apb_rsp_i.prdata, apb_req_i.paddr);
                mismatches++;
            end
            // done_o pin mirrors STATUS bit 1
            if (data_check && apb_req_i.paddr == `ISING_REG_STATUS &&
                done_i !== exp_data_i[1]) begin
                $display("Mismatch at %0t ns: done_o expected %b, got %b",
                         $time, exp_data_i[1], done_i);
                mismatches++;
            end
            if (sweep_stuck_i) begin
                $display("Error at %0t ns: the sweep never finished, done was not seen in STATUS",
                         $time);
                failures++;
            end
        end
    end

    assign mismatch_count_o = mismatches;
    assign failure_count_o  = failures;

endmodule

`default_nettype wire

//--- verification/ising_tb.sv
/*
 * Testbench for the Ising core: replays the stim file over APB,
 * polls for done and hands expected values to the checker
 */

`timescale 1ns/10ps
`default_nettype none

`include "ising_settings.svh"

module clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

endmodule

module ising_tb import ising_pkg::*; ();

    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 10;
    localparam STIM_FILE        = "verification/ising_stim.txt";

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        done;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        check_data;
    logic        sweep_stuck;
    int          mismatch_count;
    int          failure_count;
    int          assert_count;

    logic [7:0]  stim_op[$];
    logic [11:0] stim_addr[$];
    logic [31:0] stim_data[$];
    int          cycle_limit;
    int          cycle_count;
    integer      seed;

    clock_gen u_clk (
        .clk_o (clk)
    );

    ising_core_top UUT (
        .clk_i     (clk),
        .reset_i   (reset),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .done_o    (done)
    );

    ising_checker u_checker (
        .clk_i            (clk),
        .reset_i          (reset),
        .apb_req_i        (apb_req),
        .apb_rsp_i        (apb_rsp),
        .done_i           (done),
        .exp_data_i       (exp_data),
        .exp_err_i        (exp_err),
        .check_data_i     (check_data),
        .sweep_stuck_i    (sweep_stuck),
        .mismatch_count_o (mismatch_count),
        .failure_count_o  (failure_count)
    );

    // Failures of the bound property module
    assign assert_count = UUT.u_props.assert_failures;

    ////////////////////////////////////////
    // Stim file
    ////////////////////////////////////////
    task automatic load_stim(output bit ok);
        int          fd;
        int          code;
        int          sweeps;
        int          total_sweeps;
        bit          bad_line;
        string       line;
        logic [7:0]  op;
        logic [11:0] addr;
        logic [31:0] data;
        sweeps       = 0;
        total_sweeps = 0;
        bad_line     = 1'b0;
        ok           = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%c %h %h", op, addr, data) != 3) begin
                        bad_line = 1'b1;
                    end else if (op != "W" && op != "R" && op != "E" &&
                                 op != "U" && op != "P") begin
                        bad_line = 1'b1;
                    end else begin
                        stim_op.push_back(op);
                        stim_addr.push_back(addr);
                        stim_data.push_back(data);
                        if (op == "W" && addr == `ISING_REG_SWEEPS) begin
                            sweeps = int'(data[`ISING_SWEEP_BITS-1:0]);
                        end
                        if (op == "W" && addr == `ISING_REG_CTRL && data[0]) begin
                            total_sweeps += sweeps;
                        end
                    end
                end
            end
            $fclose(fd);
            ok          = !bad_line && (stim_op.size() > 0);
            cycle_limit = stim_op.size() * 4 + total_sweeps * 11 + 100;
        end
    endtask

    ////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, input logic [31:0] expect_data,
                              input logic expect_err, input logic compare,
                              output logic [31:0] rdata);
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        exp_data        = expect_data;
        exp_err         = expect_err;
        check_data      = compare;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req    = '0;
        exp_err    = 1'b0;
        check_data = 1'b0;
    endtask

    task automatic poll_done(input int max_polls);
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < max_polls) begin
            apb_access(1'b0, `ISING_REG_STATUS, '0, '0, 1'b0, 1'b0, status);
            polls++;
        end
        if (!status[1]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            sweep_stuck = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            sweep_stuck = 1'b0;
        end
    endtask

    task automatic run_stim();
        logic [31:0] rdata;
        logic [11:0] addr;
        int          cur_sweeps;
        int          start_sweeps;
        cur_sweeps   = 0;
        start_sweeps = 0;
        for (int i = 0; i < stim_op.size(); i++) begin
            case (stim_op[i])
                "W": begin
                    if (stim_addr[i] == `ISING_REG_SWEEPS) begin
                        cur_sweeps = int'(stim_data[i][`ISING_SWEEP_BITS-1:0]);
                    end
                    if (stim_addr[i] == `ISING_REG_CTRL && stim_data[i][0]) begin
                        start_sweeps = cur_sweeps;
                    end
                    apb_access(1'b1, stim_addr[i], stim_data[i], '0, 1'b0, 1'b0, rdata);
                end
                "R": apb_access(1'b0, stim_addr[i], '0, stim_data[i], 1'b0, 1'b1, rdata);
                "E": apb_access(1'b1, stim_addr[i], stim_data[i], '0, 1'b1, 1'b0, rdata);
                "U": begin
                    // Aligned offsets well above the J rows
                    addr = 12'h100 + (12'($random(seed)) & 12'h7FC);
                    apb_access(1'b0, addr, '0, '0, 1'b1, 1'b0, rdata);
                end
                "P": poll_done(start_sweeps * 11 / 3 + 8);
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Main sequence and timeout
    ////////////////////////////////////////
    initial begin
        bit ok;
        seed        = 32'hf72f;
        reset       = 1'b1;
        apb_req     = '0;
        exp_data    = '0;
        exp_err     = 1'b0;
        check_data  = 1'b0;
        sweep_stuck = 1'b0;
        cycle_limit = 0;
        load_stim(ok);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        if (ok) begin
            run_stim();
            repeat (2) @(posedge clk);
            $display("Error count: %0d mismatches, %0d assertion failures, %0d other failures",
                     mismatch_count, assert_count, failure_count);
            if (mismatch_count + assert_count + failure_count == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
        end else begin
            $display("Error: stim file %s could not be read or holds a bad line", STIM_FILE);
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: test did not end within %0d cycles, %0d mismatches, %0d other failures",
                 cycle_limit, mismatch_count, failure_count + assert_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/ising_stim.txt
# Columns: opcode, address (hex), data or expected read data (hex)
# W write, R read and compare, E write expecting pslverr, U random unmapped read, P poll done
# Reset values
R 00C 00000000
R 008 00000000
R 004 00000000
# Register readback
W 004 00000001
R 004 00000001
W 010 0E00F010
R 010 0E00F010
W 008 000000A5
R 008 000000A5
# J rows, rows 0 and 7 carry a diagonal entry
W 040 00000028
W 044 00000D02
W 048 000010D0
W 04C 00040100
W 050 00E04000
W 054 010E0000
W 058 10100000
W 05C 71000000
# One sweep, spins 1 and 6 see a zero field
W 000 00000001
P 00C 00000000
R 008 00000024
R 00C 00000202
# Two sweeps from a new vector
W 008 0000005A
W 004 00000002
W 000 00000001
P 00C 00000000
R 008 0000001B
R 00C 00000102
# Writes and a start while busy
W 008 000000A5
W 004 00000003
W 000 00000001
E 008 000000FF
R 008 000000A5
E 044 00000000
W 000 00000001
P 00C 00000000
R 008 00000024
R 00C 00000002
# Unmapped addresses and a zero-sweep start
E 0FC 12345678
U 000 00000000
W 004 00000000
W 008 00000033
W 000 00000001
P 00C 00000000
R 008 00000033
R 00C 00000002
R 004 00000000

//--- src.f
+incdir+source
source/ising_pkg.sv
source/ising_apb_regs.sv
source/coupling_mem.sv
source/sweep_sequencer.sv
source/field_accumulate.sv
source/spin_decide.sv
source/ising_core_top.sv
verification/ising_props.sv
verification/ising_checker.sv
verification/ising_tb.sv
